/* common/vlsu_cfg_pkg.sv */
package vlsu_cfg_pkg;

    // vector register group and memory path widths
    localparam int vreg_bits      = 512;
    localparam int beat_bits      = 128;
    localparam int bank_bits      = 32;
    localparam int num_banks      = 4;
    localparam int max_beats      = 4;

    // bank address is a word address with two zero byte bits appended
    localparam int word_addr_bits = 14;
    localparam int bank_addr_bits = 16;

    localparam int stride_bits    = 6;

    typedef logic [vreg_bits-1:0]      vreg_t;
    typedef logic [bank_bits-1:0]      bank_word_t;
    typedef logic [word_addr_bits-1:0] word_addr_t;
    typedef logic [bank_addr_bits-1:0] bank_addr_t;
    typedef logic [stride_bits-1:0]    stride_t;

    // counts beats 0 to max_beats-1
    typedef logic [2:0]                beat_cnt_t;

endpackage

/* common/vlsu_op_pkg.sv */
package vlsu_op_pkg;

    // load opcodes as issued by the vector core
    typedef enum logic [3:0] {
        vlsu_none   = 4'd0,
        vlsu_vle8   = 4'd1,
        vlsu_vle16  = 4'd2,
        vlsu_vle32  = 4'd3,
        vlsu_vlse8  = 4'd4,
        vlsu_vlse16 = 4'd5,
        vlsu_vlse32 = 4'd6
    } lsu_op_t;

    // register group multiplier, 0/1/2 select 1/2/4 registers
    typedef logic [2:0] lmul_t;

    typedef enum logic [1:0] {
        elem8  = 2'd0,
        elem16 = 2'd1,
        elem32 = 2'd2
    } elem_size_t;

endpackage

/* load_unit/beat_collector.sv */
`timescale 1ns/1ps

module beat_collector (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     op_active,
    input  vlsu_op_pkg::lmul_t       lmul,
    input  vlsu_cfg_pkg::word_addr_t addr,
    input  vlsu_cfg_pkg::bank_word_t bank_data0,
    input  vlsu_cfg_pkg::bank_word_t bank_data1,
    input  vlsu_cfg_pkg::bank_word_t bank_data2,
    input  vlsu_cfg_pkg::bank_word_t bank_data3,
    output vlsu_cfg_pkg::bank_addr_t bank_addr,
    output vlsu_cfg_pkg::vreg_t      group,
    output logic                     group_done
);

    vlsu_cfg_pkg::beat_cnt_t  beat_cnt;
    vlsu_cfg_pkg::beat_cnt_t  num_beats;
    vlsu_cfg_pkg::word_addr_t word_addr;
    vlsu_cfg_pkg::bank_word_t bank_word [vlsu_cfg_pkg::num_banks];
    logic                     last_beat;

    logic [vlsu_cfg_pkg::beat_bits-1:0] beat;
    logic [vlsu_cfg_pkg::max_beats-1:0][vlsu_cfg_pkg::beat_bits-1:0] slots;

    always_comb begin
        case (lmul)
            3'd1:    num_beats = 3'd2;
            3'd2:    num_beats = 3'd4;
            default: num_beats = 3'd1;
        endcase
    end

    assign last_beat = (beat_cnt == num_beats - 3'd1);

    // all banks share one word address, idle op points at the base
    assign word_addr = op_active ? addr + vlsu_cfg_pkg::word_addr_t'(beat_cnt) : addr;
    assign bank_addr = {word_addr, 2'b00};

    assign bank_word[0] = bank_data0;
    assign bank_word[1] = bank_data1;
    assign bank_word[2] = bank_data2;
    assign bank_word[3] = bank_data3;

    // bank j fills bits 32j upward of the beat
    always_comb begin
        beat = '0;
        for (int j = 0; j < vlsu_cfg_pkg::num_banks; j++) begin
            beat[j*vlsu_cfg_pkg::bank_bits +: vlsu_cfg_pkg::bank_bits] = bank_word[j];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt   <= '0;
            group_done <= 1'b0;
        end else begin
            group_done <= op_active && last_beat;
            if (!op_active || last_beat) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 3'd1;
            end
        end
    end

    // first beat of a group clears the upper slots so short groups read zero above
    always_ff @(posedge clk) begin
        if (op_active) begin
            for (int k = 0; k < vlsu_cfg_pkg::max_beats; k++) begin
                if (k == int'(beat_cnt)) begin
                    slots[k] <= beat;
                end else if (beat_cnt == '0) begin
                    slots[k] <= '0;
                end
            end
        end
    end

    assign group = slots;

endmodule

/* load_unit/stride_compactor.sv */
`timescale 1ns/1ps

module stride_compactor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    compact_start,
    input  vlsu_op_pkg::elem_size_t elem_size,
    input  vlsu_cfg_pkg::stride_t   stride,
    input  vlsu_cfg_pkg::vreg_t     group,
    output vlsu_cfg_pkg::vreg_t     compacted,
    output logic                    compact_valid
);

    vlsu_cfg_pkg::vreg_t   net [3];
    vlsu_cfg_pkg::vreg_t   picked;
    vlsu_cfg_pkg::stride_t eff_stride;

    // stride 0 behaves like stride 1
    assign eff_stride = (stride == '0) ? vlsu_cfg_pkg::stride_t'(1) : stride;

    // one selection network per element size: 8, 16 and 32 bits
    for (genvar s = 0; s < 3; s++) begin : g_size
        localparam int elem_bits = 8 << s;
        localparam int num_elems = vlsu_cfg_pkg::vreg_bits / elem_bits;
        localparam int idx_bits  = $clog2(num_elems);

        logic [num_elems-1:0][elem_bits-1:0] src_elems;
        logic [num_elems-1:0][elem_bits-1:0] dst_elems;

        assign src_elems = group;

        for (genvar i = 0; i < num_elems; i++) begin : g_elem
            logic [2*vlsu_cfg_pkg::stride_bits-1:0] src_idx;

            assign src_idx = (2*vlsu_cfg_pkg::stride_bits)'(i) *
                             (2*vlsu_cfg_pkg::stride_bits)'(eff_stride);

            // zero once the source index runs past the group
            assign dst_elems[i] = (src_idx < num_elems) ?
                                  src_elems[src_idx[idx_bits-1:0]] : '0;
        end

        assign net[s] = dst_elems;
    end

    always_comb begin
        case (elem_size)
            vlsu_op_pkg::elem8:  picked = net[0];
            vlsu_op_pkg::elem16: picked = net[1];
            default:             picked = net[2];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compact_valid <= 1'b0;
        end else begin
            compact_valid <= compact_start;
        end
    end

    always_ff @(posedge clk) begin
        if (compact_start) begin
            compacted <= picked;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir" "$log_file"

verilator --binary --timing -f vlog.f --top-module tb_vector_load_unit \
    -Mdir "$build_dir" -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Something failed" "$log_file"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0

/* src/vector_load_unit.sv */
`timescale 1ns/1ps

module vector_load_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  vlsu_op_pkg::lsu_op_t     op,
    input  vlsu_op_pkg::lmul_t       lmul,
    input  vlsu_cfg_pkg::stride_t    stride,
    input  vlsu_cfg_pkg::word_addr_t addr,
    input  vlsu_cfg_pkg::bank_word_t bank_data0,
    input  vlsu_cfg_pkg::bank_word_t bank_data1,
    input  vlsu_cfg_pkg::bank_word_t bank_data2,
    input  vlsu_cfg_pkg::bank_word_t bank_data3,
    output vlsu_cfg_pkg::bank_addr_t bank_addr,
    output vlsu_cfg_pkg::vreg_t      data_out,
    output logic                     done
);

    logic                    op_active;
    logic                    op_strided;
    vlsu_op_pkg::elem_size_t op_elem_size;

    logic                    strided_q;
    vlsu_op_pkg::elem_size_t elem_size_q;
    vlsu_cfg_pkg::stride_t   stride_q;

    vlsu_cfg_pkg::vreg_t     group;
    logic                    group_done;
    logic                    unit_done;
    logic                    compact_start;
    vlsu_cfg_pkg::vreg_t     compacted;
    logic                    compact_valid;

    always_comb begin
        op_active    = 1'b1;
        op_strided   = 1'b0;
        op_elem_size = vlsu_op_pkg::elem8;
        case (op)
            vlsu_op_pkg::vlsu_vle8:   op_elem_size = vlsu_op_pkg::elem8;
            vlsu_op_pkg::vlsu_vle16:  op_elem_size = vlsu_op_pkg::elem16;
            vlsu_op_pkg::vlsu_vle32:  op_elem_size = vlsu_op_pkg::elem32;
            vlsu_op_pkg::vlsu_vlse8: begin
                op_strided   = 1'b1;
                op_elem_size = vlsu_op_pkg::elem8;
            end
            vlsu_op_pkg::vlsu_vlse16: begin
                op_strided   = 1'b1;
                op_elem_size = vlsu_op_pkg::elem16;
            end
            vlsu_op_pkg::vlsu_vlse32: begin
                op_strided   = 1'b1;
                op_elem_size = vlsu_op_pkg::elem32;
            end
            default:                  op_active = 1'b0;
        endcase
    end

    // op may already be idle when group_done arrives, so keep what the group was loaded with
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strided_q   <= 1'b0;
            elem_size_q <= vlsu_op_pkg::elem8;
            stride_q    <= '0;
        end else if (op_active) begin
            strided_q   <= op_strided;
            elem_size_q <= op_elem_size;
            stride_q    <= stride;
        end
    end

    beat_collector beat_collector_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_active  (op_active),
        .lmul       (lmul),
        .addr       (addr),
        .bank_data0 (bank_data0),
        .bank_data1 (bank_data1),
        .bank_data2 (bank_data2),
        .bank_data3 (bank_data3),
        .bank_addr  (bank_addr),
        .group      (group),
        .group_done (group_done)
    );

    assign compact_start = group_done && strided_q;
    assign unit_done     = group_done && !strided_q;

    stride_compactor stride_compactor_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .compact_start (compact_start),
        .elem_size     (elem_size_q),
        .stride        (stride_q),
        .group         (group),
        .compacted     (compacted),
        .compact_valid (compact_valid)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done     <= 1'b0;
            data_out <= '0;
        end else begin
            done <= unit_done || compact_valid;
            if (compact_valid) begin
                data_out <= compacted;
            end else if (unit_done) begin
                data_out <= group;
            end
        end
    end

endmodule

/* verification/load_model.svh */
`ifndef LOAD_MODEL_SVH
`define LOAD_MODEL_SVH

// beats per register group, lmul 0/1/2 give 1/2/4 and anything else 1
function automatic int group_beats(input vlsu_op_pkg::lmul_t lmul_in);
    case (lmul_in)
        3'd1:    return 2;
        3'd2:    return 4;
        default: return 1;
    endcase
endfunction

function automatic bit is_strided(input vlsu_op_pkg::lsu_op_t op_in);
    return op_in == vlsu_op_pkg::vlsu_vlse8 || op_in == vlsu_op_pkg::vlsu_vlse16 ||
           op_in == vlsu_op_pkg::vlsu_vlse32;
endfunction

function automatic int elem_width(input vlsu_op_pkg::lsu_op_t op_in);
    case (op_in)
        vlsu_op_pkg::vlsu_vle16, vlsu_op_pkg::vlsu_vlse16: return 16;
        vlsu_op_pkg::vlsu_vle32, vlsu_op_pkg::vlsu_vlse32: return 32;
        default:                                           return 8;
    endcase
endfunction

// beat k comes from word addr+k, bank j at bits 32j of the beat
function automatic vlsu_cfg_pkg::vreg_t assemble_group(input vlsu_cfg_pkg::word_addr_t addr_in,
                                                       input int n);
    vlsu_cfg_pkg::vreg_t      g;
    vlsu_cfg_pkg::word_addr_t wa;
    g = '0;
    for (int k = 0; k < n; k++) begin
        wa = addr_in + vlsu_cfg_pkg::word_addr_t'(k);
        for (int j = 0; j < vlsu_cfg_pkg::num_banks; j++) begin
            g[128*k + 32*j +: 32] = mem[j][wa];
        end
    end
    return g;
endfunction

function automatic vlsu_cfg_pkg::vreg_t compact_group(input vlsu_cfg_pkg::vreg_t g,
                                                      input int eb, input int stride_in);
    vlsu_cfg_pkg::vreg_t out;
    int                  num;
    int                  step;
    int                  src;
    out  = '0;
    num  = vlsu_cfg_pkg::vreg_bits / eb;
    step = (stride_in == 0) ? 1 : stride_in;
    for (int i = 0; i < num; i++) begin
        src = i * step;
        if (src < num) begin
            for (int b = 0; b < eb; b++) begin
                out[i*eb + b] = g[src*eb + b];
            end
        end
    end
    return out;
endfunction

function automatic vlsu_cfg_pkg::vreg_t expected_result(input vlsu_op_pkg::lsu_op_t op_in,
                                                        input vlsu_cfg_pkg::stride_t stride_in,
                                                        input vlsu_cfg_pkg::vreg_t g);
    if (is_strided(op_in)) begin
        return compact_group(g, elem_width(op_in), int'(stride_in));
    end
    return g;
endfunction

task automatic check_vreg(input string name, input vlsu_cfg_pkg::vreg_t expected,
                          input vlsu_cfg_pkg::vreg_t actual);
    if (actual !== expected) begin
        report_failure($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
    end
endtask

task automatic check_addr(input string name, input vlsu_cfg_pkg::bank_addr_t expected,
                          input vlsu_cfg_pkg::bank_addr_t actual);
    if (actual !== expected) begin
        report_failure($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
    end
endtask

task automatic check_done(input string name, input logic expected, input logic actual,
                          input int cycle);
    if (expected && actual !== 1'b1) begin
        report_failure($sformatf("%s: done did not pulse in cycle %0d", name, cycle));
    end else if (actual !== expected) begin
        report_failure($sformatf("Error %s: expected %b, actual %b", name, expected, actual));
    end
endtask

`endif

/* verification/tb_vector_load_unit.sv */
`timescale 1ns/1ps

module tb_vector_load_unit;

    localparam int num_unit    = 24;
    localparam int num_strided = 24;
    localparam int num_edge    = 8;
    localparam int num_b2b     = 8;
    // stride 0/1 tests run two loads each and back-to-back tests hold two groups
    localparam int num_ops     = num_unit + num_strided + 2*num_edge + 2*num_b2b;
    localparam int watchdog_ns = (num_ops * (vlsu_cfg_pkg::max_beats + 4) * 40 + 3 * 40) * 2;

    logic                     clk;
    logic                     rst_n;
    vlsu_op_pkg::lsu_op_t     op;
    vlsu_op_pkg::lmul_t       lmul;
    vlsu_cfg_pkg::stride_t    stride;
    vlsu_cfg_pkg::word_addr_t addr;
    vlsu_cfg_pkg::bank_word_t bank_data0;
    vlsu_cfg_pkg::bank_word_t bank_data1;
    vlsu_cfg_pkg::bank_word_t bank_data2;
    vlsu_cfg_pkg::bank_word_t bank_data3;
    vlsu_cfg_pkg::bank_addr_t bank_addr;
    vlsu_cfg_pkg::vreg_t      data_out;
    logic                     done;

    vlsu_cfg_pkg::bank_word_t mem [vlsu_cfg_pkg::num_banks][2**vlsu_cfg_pkg::word_addr_bits];
    int seed;

    int                  k;

    vector_load_unit vector_load_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .lmul       (lmul),
        .stride     (stride),
        .addr       (addr),
        .bank_data0 (bank_data0),
        .bank_data1 (bank_data1),
        .bank_data2 (bank_data2),
        .bank_data3 (bank_data3),
        .bank_addr  (bank_addr),
        .data_out   (data_out),
        .done       (done)
    );

    // memory answers in the same cycle from the word part of bank_addr
    assign bank_data0 = mem[0][bank_addr[15:2]];
    assign bank_data1 = mem[1][bank_addr[15:2]];
    assign bank_data2 = mem[2][bank_addr[15:2]];
    assign bank_data3 = mem[3][bank_addr[15:2]];

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    `include "load_model.svh"

    // starts right after a falling edge and holds op for groups*N cycles before going idle
    task automatic run_load(input string name, input vlsu_op_pkg::lsu_op_t op_in,
                            input vlsu_op_pkg::lmul_t lmul_in,
                            input vlsu_cfg_pkg::stride_t stride_in,
                            input vlsu_cfg_pkg::word_addr_t addr_in, input int groups);
        int                       n;
        int                       lat;
        int                       last_cycle;
        logic                     exp_done;
        vlsu_cfg_pkg::vreg_t      expected;
        vlsu_cfg_pkg::bank_addr_t exp_addr;
        n          = group_beats(lmul_in);
        lat        = is_strided(op_in) ? 3 : 2;
        expected   = expected_result(op_in, stride_in, assemble_group(addr_in, n));
        last_cycle = groups * n + lat + 2;
        op         = op_in;
        lmul       = lmul_in;
        stride     = stride_in;
        addr       = addr_in;
        for (int c = 1; c <= last_cycle; c++) begin
            #1;
            if (c <= groups * n) begin
                exp_addr = {addr_in + vlsu_cfg_pkg::word_addr_t'((c - 1) % n), 2'b00};
            end else begin
                exp_addr = {addr_in, 2'b00};
            end
            check_addr(name, exp_addr, bank_addr);
            exp_done = (c - lat > 0) && ((c - lat) % n == 0) && ((c - lat) / n <= groups);
            check_done(name, exp_done, done, c);
            if (exp_done) begin
                check_vreg(name, expected, data_out);
            end
            @(negedge clk);
            if (c == groups * n) begin
                op = vlsu_op_pkg::vlsu_none;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        report_failure("watchdog expired before all tests finished");
    end

    initial begin
        seed       = 46462;
        rst_n      = 1'b0;
        op         = vlsu_op_pkg::vlsu_none;
        lmul       = '0;
        stride     = '0;
        addr       = '0;
        for (int b = 0; b < vlsu_cfg_pkg::num_banks; b++) begin
            for (int w = 0; w < 2**vlsu_cfg_pkg::word_addr_bits; w++) begin
                mem[b][w] = $random(seed);
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        addr = vlsu_cfg_pkg::word_addr_t'(rand_below(2**vlsu_cfg_pkg::word_addr_bits));
        #1;
        check_done("reset", 1'b0, done, 0);
        check_vreg("reset", '0, data_out);
        check_addr("reset_idle_addr", {addr, 2'b00}, bank_addr);
        @(negedge clk);

        for (int t = 0; t < num_unit; t++) begin
            run_load("unit_stride", vlsu_op_pkg::lsu_op_t'(1 + rand_below(3)),
                     vlsu_op_pkg::lmul_t'(rand_below(4)), '0,
                     vlsu_cfg_pkg::word_addr_t'(rand_below(2**14)), 1);
        end

        for (int t = 0; t < num_strided; t++) begin
            run_load("strided", vlsu_op_pkg::lsu_op_t'(4 + rand_below(3)),
                     vlsu_op_pkg::lmul_t'(rand_below(3)),
                     vlsu_cfg_pkg::stride_t'(rand_below(64)),
                     vlsu_cfg_pkg::word_addr_t'(rand_below(2**14)), 1);
        end

        // stride 0 and 1 must match the plain unit-stride load
        for (int t = 0; t < num_edge; t++) begin
            k = rand_below(3);
            lmul = vlsu_op_pkg::lmul_t'(rand_below(3));
            addr = vlsu_cfg_pkg::word_addr_t'(rand_below(2**14));
            run_load("stride01_ref", vlsu_op_pkg::lsu_op_t'(1 + k), lmul, '0, addr, 1);
            run_load("stride01", vlsu_op_pkg::lsu_op_t'(4 + k), lmul,
                     vlsu_cfg_pkg::stride_t'(t % 2), addr, 1);
        end

        for (int t = 0; t < num_b2b; t++) begin
            run_load("back_to_back", vlsu_op_pkg::lsu_op_t'(1 + rand_below(6)),
                     vlsu_op_pkg::lmul_t'(rand_below(3)),
                     vlsu_cfg_pkg::stride_t'(rand_below(64)),
                     vlsu_cfg_pkg::word_addr_t'(rand_below(2**14)), 2);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
common/vlsu_cfg_pkg.sv
common/vlsu_op_pkg.sv
load_unit/beat_collector.sv
load_unit/stride_compactor.sv
src/vector_load_unit.sv
verification/tb_vector_load_unit.sv
